// ==== tracker_pkg.sv ====
package tracker_pkg;

  // coordinate and pixel widths
  localparam int x_w     = 11;  // 1280 columns
  localparam int y_w     = 10;  // 720 rows
  localparam int pix_w   = 16;  // rgb565
  localparam int chan_w  = 8;   // one colour channel

  // centre-of-mass accumulators
  localparam int count_w = 20;  // up to 1280*720 masked pixels
  localparam int sum_w   = 31;  // sum of coordinates over a full frame
  localparam int com_latency = sum_w + 1;  // last mask out to com result

  // channel select codes, code 3 falls back to y
  localparam logic [1:0] sel_y  = 2'd0;
  localparam logic [1:0] sel_cr = 2'd1;
  localparam logic [1:0] sel_cb = 2'd2;

  // luma, scaled by 256
  localparam int y_coef_r  = 66;
  localparam int y_coef_g  = 129;
  localparam int y_coef_b  = 25;
  localparam int y_offset  = 16;

  // blue difference
  localparam int cb_coef_r = -38;
  localparam int cb_coef_g = -74;
  localparam int cb_coef_b = 112;
  localparam int cb_offset = 128;

  // red difference
  localparam int cr_coef_r = 112;
  localparam int cr_coef_g = -94;
  localparam int cr_coef_b = -18;
  localparam int cr_offset = 128;

  localparam int cvt_latency = 3;  // multiply, add, scale

endpackage

// ==== credit_ingress.sv ====
`timescale 1ns/1ps

module credit_ingress #(
  parameter int FIFO_DEPTH  = 8,
  parameter int OUT_CREDITS = 4
) (
  input  logic                          clk_pixel,
  input  logic                          recent_reset,
  input  logic                          pix_valid_i,
  input  logic [tracker_pkg::pix_w-1:0] pix_data_i,
  input  logic [tracker_pkg::x_w-1:0]   pix_x_i,
  input  logic [tracker_pkg::y_w-1:0]   pix_y_i,
  input  logic                          pix_last_i,
  input  logic                          mask_credit_i,  // one slot freed downstream
  output logic                          in_credit_o,    // one slot freed here
  output logic                          issue_valid_o,
  output logic [tracker_pkg::pix_w-1:0] issue_data_o,
  output logic [tracker_pkg::x_w-1:0]   issue_x_o,
  output logic [tracker_pkg::y_w-1:0]   issue_y_o,
  output logic                          issue_last_o
);

  localparam int ptr_w = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int cnt_w = $clog2(FIFO_DEPTH + 1);
  localparam int crd_w = $clog2(OUT_CREDITS + 1);
  localparam int ent_w = tracker_pkg::pix_w + tracker_pkg::x_w + tracker_pkg::y_w + 1;

  logic [ent_w-1:0] fifo_mem [FIFO_DEPTH];  // pixel, x, y, last
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] fill;          // entries held
  logic [crd_w-1:0] out_credits;   // free mask slots downstream
  logic             push;
  logic             pop;

  function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] p);
    next_ptr = (p == ptr_w'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;  // wrap for any depth
  endfunction

  assign push = pix_valid_i && (fill != cnt_w'(FIFO_DEPTH));  // sender never overruns
  assign pop  = (fill != '0) && (out_credits != '0);  // slot is owned from here on

  assign in_credit_o   = pop;
  assign issue_valid_o = pop;
  assign {issue_data_o, issue_x_o, issue_y_o, issue_last_o} = fifo_mem[rd_ptr];

  // storage
  always_ff @(posedge clk_pixel) begin
    if (push) begin
      fifo_mem[wr_ptr] <= {pix_data_i, pix_x_i, pix_y_i, pix_last_i};
    end
  end

  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill   <= '0;
    end else begin
      if (push) wr_ptr <= next_ptr(wr_ptr);
      if (pop)  rd_ptr <= next_ptr(rd_ptr);
      case ({push, pop})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: fill <= fill;  // both or neither
      endcase
    end
  end

  // output credits, spent at issue and returned by the receiver
  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      out_credits <= crd_w'(OUT_CREDITS);
    end else begin
      case ({pop, mask_credit_i})
        2'b10: out_credits <= out_credits - 1'b1;
        2'b01: begin
          if (out_credits != crd_w'(OUT_CREDITS)) begin
            out_credits <= out_credits + 1'b1;  // saturate at the initial grant
          end
        end
        default: out_credits <= out_credits;
      endcase
    end
  end

endmodule

// ==== ycrcb_convert.sv ====
`timescale 1ns/1ps

module ycrcb_convert (
  input  logic                           clk_pixel,
  input  logic                           recent_reset,
  input  logic                           issue_valid_i,
  input  logic [tracker_pkg::pix_w-1:0]  issue_data_i,
  input  logic [tracker_pkg::x_w-1:0]    issue_x_i,
  input  logic [tracker_pkg::y_w-1:0]    issue_y_i,
  input  logic                           issue_last_i,
  output logic                           cvt_valid_o,
  output logic [tracker_pkg::chan_w-1:0] cvt_y_o,
  output logic [tracker_pkg::chan_w-1:0] cvt_cr_o,
  output logic [tracker_pkg::chan_w-1:0] cvt_cb_o,
  output logic [tracker_pkg::x_w-1:0]    cvt_x_o,
  output logic [tracker_pkg::y_w-1:0]    cvt_y_coord_o,
  output logic                           cvt_last_o
);

  localparam int lat = tracker_pkg::cvt_latency;

  logic [tracker_pkg::chan_w-1:0] r8, g8, b8;
  logic signed [17:0] prod_y [3];  // stage 1 products, r g b
  logic signed [17:0] prod_cr [3];
  logic signed [17:0] prod_cb [3];
  logic signed [19:0] acc_y, acc_cr, acc_cb;  // stage 2 sums
  logic [lat-1:0]            valid_d;
  logic [tracker_pkg::x_w-1:0] x_d [lat];
  logic [tracker_pkg::y_w-1:0] y_d [lat];
  logic [lat-1:0]            last_d;

  function automatic logic signed [17:0] mul(input logic [7:0] c, input int k);
    mul = 18'($signed({1'b0, c}) * k);
  endfunction

  // drop the fraction, add the offset, clamp to 0..255
  function automatic logic [7:0] scale(input logic signed [19:0] acc, input int offset);
    int v;
    v = int'(acc >>> 8) + offset;
    if (v < 0)        scale = 8'd0;
    else if (v > 255) scale = 8'd255;
    else              scale = 8'(v);
  endfunction

  // 565 fields widened with zero low bits
  assign r8 = {issue_data_i[15:11], 3'b000};
  assign g8 = {issue_data_i[10:5], 2'b00};
  assign b8 = {issue_data_i[4:0], 3'b000};

  always_ff @(posedge clk_pixel) begin
    prod_y[0]  <= mul(r8, tracker_pkg::y_coef_r);
    prod_y[1]  <= mul(g8, tracker_pkg::y_coef_g);
    prod_y[2]  <= mul(b8, tracker_pkg::y_coef_b);
    prod_cr[0] <= mul(r8, tracker_pkg::cr_coef_r);
    prod_cr[1] <= mul(g8, tracker_pkg::cr_coef_g);
    prod_cr[2] <= mul(b8, tracker_pkg::cr_coef_b);
    prod_cb[0] <= mul(r8, tracker_pkg::cb_coef_r);
    prod_cb[1] <= mul(g8, tracker_pkg::cb_coef_g);
    prod_cb[2] <= mul(b8, tracker_pkg::cb_coef_b);
    acc_y  <= 20'(prod_y[0]) + 20'(prod_y[1]) + 20'(prod_y[2]) + 20'sd128;  // +128 rounds
    acc_cr <= 20'(prod_cr[0]) + 20'(prod_cr[1]) + 20'(prod_cr[2]) + 20'sd128;
    acc_cb <= 20'(prod_cb[0]) + 20'(prod_cb[1]) + 20'(prod_cb[2]) + 20'sd128;
    cvt_y_o  <= scale(acc_y, tracker_pkg::y_offset);
    cvt_cr_o <= scale(acc_cr, tracker_pkg::cr_offset);
    cvt_cb_o <= scale(acc_cb, tracker_pkg::cb_offset);
    x_d    <= {issue_x_i, x_d[0:lat-2]};  // coordinates ride alongside
    y_d    <= {issue_y_i, y_d[0:lat-2]};
    last_d <= {last_d[lat-2:0], issue_last_i};
  end

  always_ff @(posedge clk_pixel) begin
    if (recent_reset) valid_d <= '0;
    else              valid_d <= {valid_d[lat-2:0], issue_valid_i};
  end

  assign cvt_valid_o   = valid_d[lat-1];
  assign cvt_x_o       = x_d[lat-1];
  assign cvt_y_coord_o = y_d[lat-1];
  assign cvt_last_o    = last_d[lat-1];

endmodule

// ==== channel_mask.sv ====
`timescale 1ns/1ps

module channel_mask (
  input  logic                           clk_pixel,
  input  logic                           recent_reset,
  input  logic                           cvt_valid_i,
  input  logic [tracker_pkg::chan_w-1:0] cvt_y_i,
  input  logic [tracker_pkg::chan_w-1:0] cvt_cr_i,
  input  logic [tracker_pkg::chan_w-1:0] cvt_cb_i,
  input  logic [tracker_pkg::x_w-1:0]    cvt_x_i,
  input  logic [tracker_pkg::y_w-1:0]    cvt_y_coord_i,
  input  logic                           cvt_last_i,
  input  logic [1:0]                     chan_sel_i,
  input  logic [tracker_pkg::chan_w-1:0] lower_i,  // inclusive bounds
  input  logic [tracker_pkg::chan_w-1:0] upper_i,
  output logic                           mask_valid_o,
  output logic                           mask_o,
  output logic [tracker_pkg::x_w-1:0]    mask_x_o,
  output logic [tracker_pkg::y_w-1:0]    mask_y_o,
  output logic                           mask_last_o
);

  logic [tracker_pkg::chan_w-1:0] chan;  // channel under test

  always_comb begin
    case (chan_sel_i)
      tracker_pkg::sel_y:  chan = cvt_y_i;
      tracker_pkg::sel_cr: chan = cvt_cr_i;
      tracker_pkg::sel_cb: chan = cvt_cb_i;
      default:             chan = cvt_y_i;  // spare code reads as luma
    endcase
  end

  always_ff @(posedge clk_pixel) begin
    mask_o      <= (chan >= lower_i) && (chan <= upper_i);
    mask_x_o    <= cvt_x_i;
    mask_y_o    <= cvt_y_coord_i;
    mask_last_o <= cvt_last_i;
  end

  always_ff @(posedge clk_pixel) begin
    if (recent_reset) mask_valid_o <= 1'b0;
    else              mask_valid_o <= cvt_valid_i;
  end

endmodule

// ==== serial_divider.sv ====
`timescale 1ns/1ps

module serial_divider #(
  parameter int WIDTH = 31
) (
  input  logic                            clk_pixel,
  input  logic                            recent_reset,
  input  logic                            start_i,
  input  logic [WIDTH-1:0]                dividend_i,
  input  logic [tracker_pkg::count_w-1:0] divisor_i,
  output logic [WIDTH-1:0]                quotient_o,
  output logic                            done_o
);

  localparam int dw    = tracker_pkg::count_w;
  localparam int cnt_w = $clog2(WIDTH + 1);

  logic [WIDTH-1:0] quot;      // dividend shifts out the top, quotient in the bottom
  logic [dw-1:0]    rem;       // partial remainder, always below the divisor
  logic [dw-1:0]    divisor;
  logic [cnt_w-1:0] bits_left;
  logic [dw:0]      shifted;   // remainder with the next dividend bit
  logic [dw+1:0]    diff;      // top bit is the borrow

  assign shifted    = {rem, quot[WIDTH-1]};
  assign diff       = {1'b0, shifted} - {2'b00, divisor};
  assign quotient_o = quot;

  always_ff @(posedge clk_pixel) begin
    if (start_i) begin
      quot    <= dividend_i;
      rem     <= '0;
      divisor <= divisor_i;
    end else if (bits_left != '0) begin
      if (!diff[dw+1]) begin
        rem  <= diff[dw-1:0];  // subtract fits, quotient bit 1
        quot <= {quot[WIDTH-2:0], 1'b1};
      end else begin
        rem  <= shifted[dw-1:0];  // restore
        quot <= {quot[WIDTH-2:0], 1'b0};
      end
    end
  end

  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      bits_left <= '0;
      done_o    <= 1'b0;
    end else begin
      done_o <= (bits_left == cnt_w'(1));  // last bit settles this edge
      if (start_i) begin
        bits_left <= cnt_w'(WIDTH);
      end else if (bits_left != '0) begin
        bits_left <= bits_left - 1'b1;
      end
    end
  end

endmodule

// ==== centroid_accum.sv ====
`timescale 1ns/1ps

module centroid_accum (
  input  logic                         clk_pixel,
  input  logic                         recent_reset,
  input  logic                         mask_valid_i,
  input  logic                         mask_i,
  input  logic [tracker_pkg::x_w-1:0]  mask_x_i,
  input  logic [tracker_pkg::y_w-1:0]  mask_y_i,
  input  logic                         mask_last_i,
  output logic                         com_valid_o,
  output logic                         com_found_o,
  output logic [tracker_pkg::x_w-1:0]  com_x_o,
  output logic [tracker_pkg::y_w-1:0]  com_y_o
);

  localparam int sw    = tracker_pkg::sum_w;
  localparam int cw    = tracker_pkg::count_w;
  localparam int tmr_w = $clog2(tracker_pkg::com_latency + 1);

  logic [sw-1:0]    sum_x, sum_y;      // running sums for this frame
  logic [cw-1:0]    count;
  logic [sw-1:0]    total_x, total_y;  // including the pixel on the input
  logic [cw-1:0]    total_count;
  logic             hit;
  logic             frame_end;
  logic             div_start;
  logic [sw-1:0]    quot_x, quot_y;
  logic             done_x, done_y;
  logic [tmr_w-1:0] empty_tmr;         // stands in for the dividers on an empty frame
  logic             empty_done;

  assign hit         = mask_valid_i && mask_i;
  assign frame_end   = mask_valid_i && mask_last_i;
  assign total_x     = sum_x + (hit ? sw'(mask_x_i) : '0);
  assign total_y     = sum_y + (hit ? sw'(mask_y_i) : '0);
  assign total_count = count + cw'(hit);
  assign div_start   = frame_end && (total_count != '0);  // never divide by zero

  always_ff @(posedge clk_pixel) begin
    if (recent_reset || frame_end) begin
      sum_x <= '0;  // snapshot goes straight into the dividers
      sum_y <= '0;
      count <= '0;
    end else begin
      sum_x <= total_x;
      sum_y <= total_y;
      count <= total_count;
    end
  end

  // empty frame, same latency as a division
  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      empty_tmr  <= '0;
      empty_done <= 1'b0;
    end else begin
      empty_done <= (empty_tmr == tmr_w'(1));
      if (frame_end && !div_start) begin
        empty_tmr <= tmr_w'(tracker_pkg::com_latency - 1);
      end else if (empty_tmr != '0) begin
        empty_tmr <= empty_tmr - 1'b1;
      end
    end
  end

  serial_divider #(.WIDTH(sw)) div_x_i (
    .clk_pixel    (clk_pixel),
    .recent_reset (recent_reset),
    .start_i      (div_start),
    .dividend_i   (total_x),
    .divisor_i    (total_count),
    .quotient_o   (quot_x),
    .done_o       (done_x)
  );

  serial_divider #(.WIDTH(sw)) div_y_i (
    .clk_pixel    (clk_pixel),
    .recent_reset (recent_reset),
    .start_i      (div_start),
    .dividend_i   (total_y),
    .divisor_i    (total_count),
    .quotient_o   (quot_y),
    .done_o       (done_y)
  );

  assign com_found_o = done_x && done_y;  // both finish on the same edge
  assign com_valid_o = com_found_o || empty_done;
  assign com_x_o     = com_found_o ? quot_x[tracker_pkg::x_w-1:0] : '0;  // mean fits a coordinate
  assign com_y_o     = com_found_o ? quot_y[tracker_pkg::y_w-1:0] : '0;

endmodule

// ==== color_tracker_top.sv ====
`timescale 1ns/1ps

module color_tracker_top #(
  parameter int FIFO_DEPTH  = 8,
  parameter int OUT_CREDITS = 4
) (
  input  logic                           clk_pixel,
  input  logic                           recent_reset,
  input  logic                           pix_valid_i,
  input  logic [tracker_pkg::pix_w-1:0]  pix_data_i,
  input  logic [tracker_pkg::x_w-1:0]    pix_x_i,
  input  logic [tracker_pkg::y_w-1:0]    pix_y_i,
  input  logic                           pix_last_i,
  input  logic                           mask_credit_i,
  input  logic [1:0]                     chan_sel_i,
  input  logic [tracker_pkg::chan_w-1:0] lower_i,
  input  logic [tracker_pkg::chan_w-1:0] upper_i,
  output logic                           in_credit_o,
  output logic                           mask_valid_o,
  output logic                           mask_o,
  output logic [tracker_pkg::x_w-1:0]    mask_x_o,
  output logic [tracker_pkg::y_w-1:0]    mask_y_o,
  output logic                           mask_last_o,
  output logic                           com_valid_o,
  output logic                           com_found_o,
  output logic [tracker_pkg::x_w-1:0]    com_x_o,
  output logic [tracker_pkg::y_w-1:0]    com_y_o
);

  // issue from the ingress FIFO
  logic                           issue_valid, issue_last;
  logic [tracker_pkg::pix_w-1:0]  issue_data;
  logic [tracker_pkg::x_w-1:0]    issue_x;
  logic [tracker_pkg::y_w-1:0]    issue_y;
  // converted pixel
  logic                           cvt_valid, cvt_last;
  logic [tracker_pkg::chan_w-1:0] cvt_y, cvt_cr, cvt_cb;
  logic [tracker_pkg::x_w-1:0]    cvt_x;
  logic [tracker_pkg::y_w-1:0]    cvt_y_coord;

  credit_ingress #(.FIFO_DEPTH(FIFO_DEPTH), .OUT_CREDITS(OUT_CREDITS)) credit_ingress_i (
    .clk_pixel(clk_pixel), .recent_reset(recent_reset),
    .pix_valid_i(pix_valid_i), .pix_data_i(pix_data_i), .pix_x_i(pix_x_i),
    .pix_y_i(pix_y_i), .pix_last_i(pix_last_i), .mask_credit_i(mask_credit_i),
    .in_credit_o(in_credit_o), .issue_valid_o(issue_valid), .issue_data_o(issue_data),
    .issue_x_o(issue_x), .issue_y_o(issue_y), .issue_last_o(issue_last)
  );

  ycrcb_convert ycrcb_convert_i (
    .clk_pixel(clk_pixel), .recent_reset(recent_reset),
    .issue_valid_i(issue_valid), .issue_data_i(issue_data), .issue_x_i(issue_x),
    .issue_y_i(issue_y), .issue_last_i(issue_last),
    .cvt_valid_o(cvt_valid), .cvt_y_o(cvt_y), .cvt_cr_o(cvt_cr), .cvt_cb_o(cvt_cb),
    .cvt_x_o(cvt_x), .cvt_y_coord_o(cvt_y_coord), .cvt_last_o(cvt_last)
  );

  channel_mask channel_mask_i (
    .clk_pixel(clk_pixel), .recent_reset(recent_reset),
    .cvt_valid_i(cvt_valid), .cvt_y_i(cvt_y), .cvt_cr_i(cvt_cr), .cvt_cb_i(cvt_cb),
    .cvt_x_i(cvt_x), .cvt_y_coord_i(cvt_y_coord), .cvt_last_i(cvt_last),
    .chan_sel_i(chan_sel_i), .lower_i(lower_i), .upper_i(upper_i),
    .mask_valid_o(mask_valid_o), .mask_o(mask_o), .mask_x_o(mask_x_o),
    .mask_y_o(mask_y_o), .mask_last_o(mask_last_o)
  );

  centroid_accum centroid_accum_i (
    .clk_pixel(clk_pixel), .recent_reset(recent_reset),
    .mask_valid_i(mask_valid_o), .mask_i(mask_o), .mask_x_i(mask_x_o),
    .mask_y_i(mask_y_o), .mask_last_i(mask_last_o),
    .com_valid_o(com_valid_o), .com_found_o(com_found_o),
    .com_x_o(com_x_o), .com_y_o(com_y_o)
  );

endmodule

// ==== tb_color_tracker_props.sv ====
`timescale 1ns/1ps

module tb_color_tracker_props #(
  parameter int OUT_CREDITS = 4
) (
  input logic clk_pixel,
  input logic recent_reset,
  input logic pix_valid_i,
  input logic mask_credit_i,
  input logic in_credit_o,
  input logic mask_valid_o,
  input logic mask_last_o,
  input logic com_valid_o,
  input logic com_found_o
);

  int masks_out;      // mask outputs so far
  int credits_back;   // credits returned by the receiver
  int pixels_in;      // input strobes
  int credits_given;  // in_credit_o pulses
  int fail_count = 0;

  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      masks_out     <= 0;
      credits_back  <= 0;
      pixels_in     <= 0;
      credits_given <= 0;
    end else begin
      masks_out     <= masks_out + int'(mask_valid_o);
      credits_back  <= credits_back + int'(mask_credit_i);
      pixels_in     <= pixels_in + int'(pix_valid_i);
      credits_given <= credits_given + int'(in_credit_o);
    end
  end

  out_credit_bound_a: assert property (@(posedge clk_pixel) disable iff (recent_reset)
    masks_out + int'(mask_valid_o) <= OUT_CREDITS + credits_back)
    else begin
      $error("mask outputs exceed the output credits granted");
      fail_count++;
    end

  in_credit_bound_a: assert property (@(posedge clk_pixel) disable iff (recent_reset)
    credits_given + int'(in_credit_o) <= pixels_in)
    else begin
      $error("more input credits returned than pixels sent");
      fail_count++;
    end

  reset_quiet_a: assert property (@(posedge clk_pixel)
    recent_reset |=> !in_credit_o && !mask_valid_o && !com_valid_o && !com_found_o)
    else begin
      $error("outputs active during or right after reset");
      fail_count++;
    end

  // result lands exactly com_latency after the frame's last mask, never elsewhere
  com_after_last_a: assert property (@(posedge clk_pixel) disable iff (recent_reset)
    mask_valid_o && mask_last_o |-> ##(tracker_pkg::com_latency) com_valid_o)
    else begin
      $error("centre of mass missing at its fixed latency");
      fail_count++;
    end

  com_has_frame_a: assert property (@(posedge clk_pixel) disable iff (recent_reset)
    com_valid_o |-> $past(mask_valid_o && mask_last_o, tracker_pkg::com_latency))
    else begin
      $error("centre of mass with no frame end before it");
      fail_count++;
    end

endmodule

// ==== tb_color_tracker.sv ====
`timescale 1ns/1ps

module tb_color_tracker;

  localparam int fifo_depth   = 8;
  localparam int out_credits  = 4;
  localparam int half_period  = 4;    // 8 ns pixel clock
  localparam int reset_cycles = 10;
  localparam int wait_limit   = 400;  // cycles any single wait may take
  localparam int frame_len    = 40;   // at least com_latency pixels
  localparam int ent_w        = tracker_pkg::x_w + tracker_pkg::y_w + 2;

  logic                           clk_pixel;
  logic                           recent_reset;
  logic                           pix_valid_i;
  logic [tracker_pkg::pix_w-1:0]  pix_data_i;
  logic [tracker_pkg::x_w-1:0]    pix_x_i;
  logic [tracker_pkg::y_w-1:0]    pix_y_i;
  logic                           pix_last_i;
  logic                           mask_credit_i = 1'b0;
  logic [1:0]                     chan_sel_i;
  logic [tracker_pkg::chan_w-1:0] lower_i;
  logic [tracker_pkg::chan_w-1:0] upper_i;
  logic                           in_credit_o;
  logic                           mask_valid_o;
  logic                           mask_o;
  logic [tracker_pkg::x_w-1:0]    mask_x_o;
  logic [tracker_pkg::y_w-1:0]    mask_y_o;
  logic                           mask_last_o;
  logic                           com_valid_o;
  logic                           com_found_o;
  logic [tracker_pkg::x_w-1:0]    com_x_o;
  logic [tracker_pkg::y_w-1:0]    com_y_o;

  logic [ent_w-1:0] exp_q [$];  // mask, x, y, last for every pixel in flight
  int com_due_q [$];            // expected centre of mass, one entry per frame
  int com_found_q [$];
  int com_x_q [$];
  int com_y_q [$];
  int errors = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int sender_credits = fifo_depth;
  int credits_owed = 0;  // mask outputs not yet credited back
  int sent_count = 0;
  int in_pulses = 0;
  int masks_seen = 0;
  int cycle = 0;
  int sum_x = 0;
  int sum_y = 0;
  int hits = 0;
  int last_found = 0;
  bit hold_credits = 1'b0;  // receiver withholds credits

  color_tracker_top #(.FIFO_DEPTH(fifo_depth), .OUT_CREDITS(out_credits))
    color_tracker_top_i (.*);

  bind color_tracker_top tb_color_tracker_props #(.OUT_CREDITS(OUT_CREDITS)) props_i (
    .clk_pixel(clk_pixel), .recent_reset(recent_reset), .pix_valid_i(pix_valid_i),
    .mask_credit_i(mask_credit_i), .in_credit_o(in_credit_o),
    .mask_valid_o(mask_valid_o), .mask_last_o(mask_last_o),
    .com_valid_o(com_valid_o), .com_found_o(com_found_o)
  );

  initial begin
    clk_pixel = 1'b0;
    forever #(half_period) clk_pixel = ~clk_pixel;
  end

  // bt.601 style conversion of one 565 pixel, then the selected channel
  function automatic int channel_value(input logic [15:0] pix, input logic [1:0] sel);
    int r, g, b, acc;
    r = int'({pix[15:11], 3'b000});  // fields padded with zero low bits
    g = int'({pix[10:5], 2'b00});
    b = int'({pix[4:0], 3'b000});
    case (sel)
      tracker_pkg::sel_cr: acc = ((tracker_pkg::cr_coef_r * r + tracker_pkg::cr_coef_g * g
                                  + tracker_pkg::cr_coef_b * b + 128) >>> 8)
                                 + tracker_pkg::cr_offset;
      tracker_pkg::sel_cb: acc = ((tracker_pkg::cb_coef_r * r + tracker_pkg::cb_coef_g * g
                                  + tracker_pkg::cb_coef_b * b + 128) >>> 8)
                                 + tracker_pkg::cb_offset;
      default:             acc = ((tracker_pkg::y_coef_r * r + tracker_pkg::y_coef_g * g
                                  + tracker_pkg::y_coef_b * b + 128) >>> 8)
                                 + tracker_pkg::y_offset;
    endcase
    if (acc < 0) acc = 0;
    else if (acc > 255) acc = 255;
    return acc;
  endfunction

  task automatic check_value(input string name, input int got, input int want);
    assert (got == want) else begin
      $display("FAILED t=%0t %s expected %0d got %0d", $time, name, want, got);
      errors++;
    end
  endtask

  task automatic check_mask();
    logic [ent_w-1:0] head;
    int x, y;
    masks_seen++;
    credits_owed++;  // consumed, credit goes back when allowed
    if (exp_q.size() == 0) begin
      $display("mask output at %0t with no pixel in flight", $time);
      errors++;
    end else begin
      head = exp_q.pop_front();
      x = int'(head[ent_w-2 -: tracker_pkg::x_w]);
      y = int'(head[tracker_pkg::y_w:1]);
      check_value("mask_o", int'(mask_o), int'(head[ent_w-1]));
      check_value("mask_x_o", int'(mask_x_o), x);
      check_value("mask_y_o", int'(mask_y_o), y);
      check_value("mask_last_o", int'(mask_last_o), int'(head[0]));
      if (head[ent_w-1]) begin
        sum_x += x;
        sum_y += y;
        hits++;
      end
      if (head[0]) begin  // frame closes, centre of mass due later
        com_due_q.push_back(cycle + tracker_pkg::com_latency);
        com_found_q.push_back(hits != 0 ? 1 : 0);
        com_x_q.push_back(hits != 0 ? sum_x / hits : 0);  // floor, sums are positive
        com_y_q.push_back(hits != 0 ? sum_y / hits : 0);
        sum_x = 0;
        sum_y = 0;
        hits  = 0;
      end
    end
  endtask

  task automatic check_com();
    if (com_due_q.size() == 0) begin
      $display("com_valid_o at %0t with no frame ended", $time);
      errors++;
    end else begin
      check_value("com_valid_o cycle", cycle, com_due_q.pop_front());
      last_found = int'(com_found_o);
      check_value("com_found_o", last_found, com_found_q.pop_front());
      check_value("com_x_o", int'(com_x_o), com_x_q.pop_front());
      check_value("com_y_o", int'(com_y_o), com_y_q.pop_front());
    end
  endtask

  // outputs are sampled mid cycle
  always @(negedge clk_pixel) begin
    cycle++;
    if (recent_reset) begin
      check_value("in_credit_o", int'(in_credit_o), 0);
      check_value("mask_valid_o", int'(mask_valid_o), 0);
      check_value("com_valid_o", int'(com_valid_o), 0);
    end else begin
      if (in_credit_o) begin
        sender_credits++;
        in_pulses++;
      end
      if (mask_valid_o) check_mask();
      if (com_valid_o) check_com();
    end
  end

  // receiver hands back one credit per cycle
  always @(posedge clk_pixel) begin
    #1;
    if (!hold_credits && credits_owed > 0) begin
      mask_credit_i = 1'b1;
      credits_owed--;
    end else begin
      mask_credit_i = 1'b0;
    end
  end

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge clk_pixel);
    #1;
  endtask

  task automatic send_pixel(input logic [15:0] data, input int x, input int y, input bit last);
    int waited;
    int chan;
    waited = 0;
    while (sender_credits == 0 && waited < wait_limit) begin
      @(posedge clk_pixel);
      #1;
      waited++;
    end
    if (sender_credits == 0) begin
      $display("input credit never came back within %0d cycles at %0t", waited, $time);
      errors++;
    end else begin
      chan = channel_value(data, chan_sel_i);
      exp_q.push_back({(chan >= int'(lower_i)) && (chan <= int'(upper_i)),
                       x[tracker_pkg::x_w-1:0], y[tracker_pkg::y_w-1:0], last});
      pix_valid_i = 1'b1;
      pix_data_i  = data;
      pix_x_i     = x[tracker_pkg::x_w-1:0];
      pix_y_i     = y[tracker_pkg::y_w-1:0];
      pix_last_i  = last;
      sender_credits--;  // one credit per strobe
      sent_count++;
      @(posedge clk_pixel);
      #1;
      pix_valid_i = 1'b0;
      pix_last_i  = 1'b0;
    end
  endtask

  task automatic send_random(input int n, input bit last_at_end);
    for (int i = 0; i < n; i++) begin
      send_pixel(16'($urandom), int'($urandom_range(0, 1279)), int'($urandom_range(0, 719)),
                 last_at_end && (i == n - 1));
    end
  endtask

  function automatic bit pipeline_busy();
    return exp_q.size() != 0 || com_due_q.size() != 0 || credits_owed != 0;
  endfunction

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (pipeline_busy() && waited < wait_limit) begin
      @(posedge clk_pixel);
      #1;
      waited++;
    end
    if (pipeline_busy()) begin
      $display("pipeline did not drain within %0d cycles at %0t", wait_limit, $time);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int errs_at_start);
    tests_run++;
    if (errors == errs_at_start) begin
      $display("test %s passed", name);
    end else begin
      tests_failed++;
      $display("test %s failed with %0d errors", name, errors - errs_at_start);
    end
  endtask

  initial begin
    int start;
    int base_sent;
    int base_pulses;
    int base_masks;
    int props_fails;
    void'($urandom(32'hb884477f));  // one seed for the whole run
    recent_reset = 1'b1;
    pix_valid_i  = 1'b0;
    pix_data_i   = '0;
    pix_x_i      = '0;
    pix_y_i      = '0;
    pix_last_i   = 1'b0;
    chan_sel_i   = tracker_pkg::sel_y;
    lower_i      = '0;
    upper_i      = '1;
    repeat (reset_cycles) @(posedge clk_pixel);
    #1;
    recent_reset = 1'b0;

    // reset, nothing comes out before a pixel goes in
    start = errors;
    idle_cycles(8);
    check_value("mask_valid_o count", masks_seen, 0);
    report_test("reset", start);

    // mask per channel
    start = errors;
    for (int sel = 0; sel < 3; sel++) begin
      chan_sel_i = 2'(sel);
      lower_i    = 8'($urandom_range(0, 160));
      upper_i    = lower_i + 8'($urandom_range(20, 95));
      send_random(frame_len, 1'b1);
      wait_drain();
    end
    report_test("mask per channel", start);

    // input credits balance
    start       = errors;
    base_sent   = sent_count;
    base_pulses = in_pulses;
    send_random(frame_len, 1'b1);
    wait_drain();
    check_value("in_credit_o pulses", in_pulses - base_pulses, sent_count - base_sent);
    check_value("sender credits", sender_credits, fifo_depth);
    report_test("input credits", start);

    // back-pressure, fill FIFO and pipeline then release
    start        = errors;
    base_masks   = masks_seen;
    hold_credits = 1'b1;
    send_random(fifo_depth + out_credits, 1'b0);
    idle_cycles(24);
    check_value("mask_valid_o count", masks_seen - base_masks, out_credits);
    hold_credits = 1'b0;
    send_random(frame_len - fifo_depth - out_credits, 1'b1);
    wait_drain();
    report_test("back-pressure", start);

    // centre of mass, white block on black in an 8x8 frame
    start      = errors;
    chan_sel_i = tracker_pkg::sel_y;
    lower_i    = 8'd200;
    upper_i    = 8'd255;
    for (int j = 0; j < 8; j++) begin
      for (int i = 0; i < 8; i++) begin
        send_pixel((i >= 2 && i <= 5 && j >= 1 && j <= 3) ? 16'hffff : 16'h0000,
                   100 + i, 50 + j, (i == 7) && (j == 7));
      end
    end
    wait_drain();
    check_value("com_found_o", last_found, 1);
    report_test("centre of mass", start);

    // empty frame, all black with the same window
    start = errors;
    for (int i = 0; i < frame_len; i++) begin
      send_pixel(16'h0000, i, 7, i == frame_len - 1);
    end
    wait_drain();
    check_value("com_found_o", last_found, 0);
    report_test("empty frame", start);

    props_fails = color_tracker_top_i.props_i.fail_count;
    $display("%0d tests run, %0d failed, %0d failed checks, %0d assertion failures",
             tests_run, tests_failed, errors, props_fails);
    if (errors == 0 && props_fails == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // watchdog against a hung run
  initial begin
    #200000;
    $display("simulation ran past its time limit");
    $display("** FAIL **");
    $finish;
  end

endmodule

// ==== list.f ====
tracker_pkg.sv
credit_ingress.sv
ycrcb_convert.sv
channel_mask.sv
serial_divider.sv
centroid_accum.sv
color_tracker_top.sv
tb_color_tracker_props.sv
tb_color_tracker.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module tb_color_tracker

# assertion errors must not stop the run before the summary
out=$(./obj_dir/Vtb_color_tracker +verilator+error+limit+1000 2>&1) || true
echo "$out"

if echo "$out" | grep -qxF '** PASS **'; then
  exit 0
fi
exit 1
